// File: src/backend_pkg.sv
package backend_pkg;

    // rv32i widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int STRB_W     = XLEN / 8;
    localparam int OFS_W      = $clog2(STRB_W);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [OFS_W-1:0]      byte_ofs_t;

    // integer register write
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        word_t     data;
    } csr_wr_t;

    // strb is the size mask, aligned to lane 0
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     addr;
        strb_t     strb;
        logic      signed_ld;
    } mem_rd_t;

    // store data sits in the low lanes, same as strb
    typedef struct packed {
        logic  valid;
        word_t addr;
        strb_t strb;
        word_t data;
    } mem_wr_t;

    typedef struct packed {
        logic  take;
        word_t pc;
    } jump_t;

    // everything the execute stage produces for one instruction
    typedef struct packed {
        reg_wr_t reg_wr;
        csr_wr_t csr_wr;
        mem_rd_t mem_rd;
        mem_wr_t mem_wr;
        jump_t   jmp;
    } exec_bundle_t;

    // data bus request, strb and wdata already on their lanes
    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        word_t addr;
        strb_t strb;
        word_t wdata;
    } mem_req_t;

    // load waiting for rdata in stage two
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        byte_ofs_t offset;
        strb_t     strb;
        logic      signed_ld;
    } ld_info_t;

endpackage

// File: src/pipe_cushion.sv
module pipe_cushion (
    input  logic                     CLK,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     mem_wait,
    input  backend_pkg::exec_bundle_t exec,
    output backend_pkg::exec_bundle_t cush
);

    import backend_pkg::*;

    exec_bundle_t cush_d;

    // flush wins over the memory stall
    always_comb begin
        cush_d = cush;
        if (flush) begin
            cush_d = '0;
        end else if (!mem_wait) begin
            cush_d = exec;
        end
    end

    // execute to memory stage register
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cush <= '0;
        end else begin
            cush <= cush_d;
        end
    end

endmodule

// File: src/mem_access.sv
module mem_access (
    input  logic                     CLK,
    input  logic                     rst_n,
    input  logic                     mem_wait,
    input  backend_pkg::exec_bundle_t cush,
    output backend_pkg::mem_req_t     mem_req,
    output backend_pkg::reg_wr_t      wb_reg,
    output backend_pkg::csr_wr_t      csr_wr,
    output backend_pkg::ld_info_t     ld_info
);

    import backend_pkg::*;

    byte_ofs_t wr_ofs;
    byte_ofs_t rd_ofs;
    ld_info_t  ld_next;

    logic      reg_vld_q;
    logic      csr_vld_q;
    logic      ld_vld_q;
    reg_wr_t   reg_q;
    csr_wr_t   csr_q;
    ld_info_t  ld_q;

    assign wr_ofs = cush.mem_wr.addr[OFS_W-1:0];
    assign rd_ofs = cush.mem_rd.addr[OFS_W-1:0];

    // bus request straight from the cushion
    always_comb begin
        mem_req       = '0;
        mem_req.rd_en = cush.mem_rd.valid;
        mem_req.wr_en = cush.mem_wr.valid;
        if (cush.mem_wr.valid) begin
            mem_req.addr  = cush.mem_wr.addr;
            mem_req.strb  = cush.mem_wr.strb << wr_ofs;
            mem_req.wdata = cush.mem_wr.data << {wr_ofs, 3'b000};
        end else if (cush.mem_rd.valid) begin
            mem_req.addr = cush.mem_rd.addr;
            mem_req.strb = cush.mem_rd.strb << rd_ofs;
        end
    end

    always_comb begin
        ld_next.valid     = cush.mem_rd.valid;
        ld_next.rd        = cush.mem_rd.rd;
        ld_next.offset    = rd_ofs;
        ld_next.strb      = cush.mem_rd.strb;
        ld_next.signed_ld = cush.mem_rd.signed_ld;
    end

    // stage two valids drop to a bubble while the bus waits
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            reg_vld_q <= 1'b0;
            csr_vld_q <= 1'b0;
            ld_vld_q  <= 1'b0;
        end else begin
            reg_vld_q <= cush.reg_wr.valid & ~mem_wait;
            csr_vld_q <= cush.csr_wr.valid & ~mem_wait;
            ld_vld_q  <= ld_next.valid & ~mem_wait;
        end
    end

    // stage two payload
    always_ff @(posedge CLK) begin
        reg_q <= cush.reg_wr;
        csr_q <= cush.csr_wr;
        ld_q  <= ld_next;
    end

    always_comb begin
        wb_reg        = reg_q;
        wb_reg.valid  = reg_vld_q;
        csr_wr        = csr_q;
        csr_wr.valid  = csr_vld_q;
        ld_info       = ld_q;
        ld_info.valid = ld_vld_q;
    end

endmodule

// File: src/load_writeback.sv
module load_writeback (
    input  backend_pkg::reg_wr_t  wb_reg,
    input  backend_pkg::ld_info_t ld_info,
    input  backend_pkg::word_t    rdata,
    output backend_pkg::reg_wr_t  rf_wr
);

    import backend_pkg::*;

    word_t     shifted;
    word_t     ld_data;
    byte_ofs_t top_lane;
    logic      fill;

    // move the addressed bytes down to lane 0
    assign shifted = rdata >> {ld_info.offset, 3'b000};

    // highest lane in the size mask carries the sign
    always_comb begin
        top_lane = '0;
        for (int lane = 0; lane < STRB_W; lane++) begin
            if (ld_info.strb[lane]) begin
                top_lane = byte_ofs_t'(lane);
            end
        end
    end

    assign fill = ld_info.signed_ld & shifted[{top_lane, 3'b111}];

    always_comb begin
        for (int lane = 0; lane < STRB_W; lane++) begin
            if (ld_info.strb[lane]) begin
                ld_data[lane*8 +: 8] = shifted[lane*8 +: 8];
            end else begin
                ld_data[lane*8 +: 8] = {8{fill}};
            end
        end
    end

    // a pending load owns the write port
    always_comb begin
        if (ld_info.valid) begin
            rf_wr.valid = 1'b1;
            rf_wr.rd    = ld_info.rd;
            rf_wr.data  = ld_data;
        end else begin
            rf_wr = wb_reg;
        end
        // x0 is hardwired
        if (rf_wr.rd == '0) begin
            rf_wr.valid = 1'b0;
        end
    end

endmodule

// File: src/backend_top.sv
module backend_top (
    input  logic                     CLK,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     mem_wait,
    input  backend_pkg::exec_bundle_t exec,
    input  backend_pkg::word_t        rdata,
    output backend_pkg::mem_req_t     mem_req,
    output backend_pkg::reg_wr_t      rf_wr,
    output backend_pkg::csr_wr_t      csr_wr,
    output backend_pkg::jump_t        jmp
);

    import backend_pkg::*;

    exec_bundle_t cush;
    reg_wr_t      wb_reg;
    ld_info_t     ld_info;

    // execute to memory register
    pipe_cushion u_cushion (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .mem_wait (mem_wait),
        .exec     (exec),
        .cush     (cush)
    );

    // redirect goes to fetch one cycle after capture
    assign jmp = cush.jmp;

    mem_access u_mem (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .mem_wait (mem_wait),
        .cush     (cush),
        .mem_req  (mem_req),
        .wb_reg   (wb_reg),
        .csr_wr   (csr_wr),
        .ld_info  (ld_info)
    );

    // rdata belongs to the load held in stage two
    load_writeback u_wb (
        .wb_reg  (wb_reg),
        .ld_info (ld_info),
        .rdata   (rdata),
        .rf_wr   (rf_wr)
    );

endmodule

// File: verification/backend_checker.sv
module backend_checker (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      mem_wait,
    input  backend_pkg::exec_bundle_t exec,
    input  backend_pkg::mem_req_t     mem_req,
    input  backend_pkg::reg_wr_t      rf_wr,
    input  backend_pkg::csr_wr_t      csr_wr,
    input  backend_pkg::jump_t        jmp,
    output int                        error_count,
    output logic                      idle
);

    import backend_pkg::*;

    // own copy of the data memory, same fill as the bus model
    word_t        shadow [256];
    exec_bundle_t m_cush;
    reg_wr_t      m_reg;
    csr_wr_t      m_csr;
    reg_wr_t      m_ld;
    mem_req_t     prev_req;
    logic         prev_hold;

    initial begin
        error_count = 0;
        prev_hold   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 32'h9e37_79b1 * (i + 1);
        end
    end

    // bus request as the cushion item asks for it
    function automatic mem_req_t expect_req(exec_bundle_t c);
        mem_req_t r;
        r       = '0;
        r.rd_en = c.mem_rd.valid;
        r.wr_en = c.mem_wr.valid;
        if (c.mem_wr.valid) begin
            r.addr  = c.mem_wr.addr;
            r.strb  = c.mem_wr.strb << c.mem_wr.addr[1:0];
            r.wdata = c.mem_wr.data << (8 * c.mem_wr.addr[1:0]);
        end else if (c.mem_rd.valid) begin
            r.addr = c.mem_rd.addr;
            r.strb = c.mem_rd.strb << c.mem_rd.addr[1:0];
        end
        return r;
    endfunction

    // byte, half or word load, picked by the size mask
    function automatic word_t load_value(word_t mem_word, logic [1:0] ofs, strb_t size,
                                         logic sgn);
        word_t w;
        w = mem_word >> (8 * ofs);
        case (size)
            4'b0001: return sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
            4'b0011: return sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic compare(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            error_count++;
            $display("CHECK FAILED time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        end
    endtask

    always @(posedge CLK) begin
        mem_req_t exp_req;
        reg_wr_t  exp_rf;
        if (!rst_n) begin
            m_cush    = '0;
            m_reg     = '0;
            m_csr     = '0;
            m_ld      = '0;
            prev_hold = 1'b0;
            idle      = 1'b1;
        end else begin
            exp_req = expect_req(m_cush);
            compare("mem_req.rd_en", exp_req.rd_en, mem_req.rd_en);
            compare("mem_req.wr_en", exp_req.wr_en, mem_req.wr_en);
            if (exp_req.rd_en || exp_req.wr_en) begin
                compare("mem_req.addr", exp_req.addr, mem_req.addr);
                compare("mem_req.strb", exp_req.strb, mem_req.strb);
            end
            if (exp_req.wr_en) begin
                compare("mem_req.wdata", exp_req.wdata, mem_req.wdata);
            end
            if (prev_hold) begin
                compare("mem_req (held during wait)", prev_req, mem_req);
            end

            compare("jmp.take", m_cush.jmp.take, jmp.take);
            if (m_cush.jmp.take) begin
                compare("jmp.pc", m_cush.jmp.pc, jmp.pc);
            end

            compare("csr_wr.valid", m_csr.valid, csr_wr.valid);
            if (m_csr.valid) begin
                compare("csr_wr.addr", m_csr.addr, csr_wr.addr);
                compare("csr_wr.data", m_csr.data, csr_wr.data);
            end

            // pending load owns the port, x0 is never written
            exp_rf = m_ld.valid ? m_ld : m_reg;
            if (exp_rf.rd == 5'd0) begin
                exp_rf.valid = 1'b0;
            end
            compare("rf_wr.valid", exp_rf.valid, rf_wr.valid);
            if (exp_rf.valid) begin
                compare("rf_wr.rd", exp_rf.rd, rf_wr.rd);
                compare("rf_wr.data", exp_rf.data, rf_wr.data);
            end

            // accepted store updates the shadow memory
            if (exp_req.wr_en && !mem_wait) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (exp_req.strb[lane]) begin
                        shadow[exp_req.addr[9:2]][lane*8 +: 8] = exp_req.wdata[lane*8 +: 8];
                    end
                end
            end

            // stage two gets a bubble while the bus waits
            m_ld = '0;
            if (m_cush.mem_rd.valid && !mem_wait) begin
                m_ld.valid = 1'b1;
                m_ld.rd    = m_cush.mem_rd.rd;
                m_ld.data  = load_value(shadow[m_cush.mem_rd.addr[9:2]],
                                        m_cush.mem_rd.addr[1:0], m_cush.mem_rd.strb,
                                        m_cush.mem_rd.signed_ld);
            end
            m_reg       = m_cush.reg_wr;
            m_reg.valid = m_cush.reg_wr.valid && !mem_wait;
            m_csr       = m_cush.csr_wr;
            m_csr.valid = m_cush.csr_wr.valid && !mem_wait;

            prev_hold = mem_wait && !flush && (exp_req.rd_en || exp_req.wr_en);
            prev_req  = mem_req;

            if (flush) begin
                m_cush = '0;
            end else if (!mem_wait) begin
                m_cush = exec;
            end

            idle = !(m_cush.reg_wr.valid || m_cush.csr_wr.valid || m_cush.mem_rd.valid ||
                     m_cush.mem_wr.valid || m_cush.jmp.take || m_reg.valid ||
                     m_csr.valid || m_ld.valid);
        end
    end

endmodule

// File: verification/backend_tb.sv
module backend_tb;

    import backend_pkg::*;

    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 20;

    logic         CLK;
    logic         rst_n;
    logic         flush;
    logic         mem_wait;
    exec_bundle_t exec;
    word_t        rdata;
    mem_req_t     mem_req;
    reg_wr_t      rf_wr;
    csr_wr_t      csr_wr;
    jump_t        jmp;

    word_t        mem [256];
    int           checker_errors;
    int           tb_errors;
    logic         model_idle;
    logic         dut_active;

    backend_top uut (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .mem_wait (mem_wait),
        .exec     (exec),
        .rdata    (rdata),
        .mem_req  (mem_req),
        .rf_wr    (rf_wr),
        .csr_wr   (csr_wr),
        .jmp      (jmp)
    );

    backend_checker u_checker (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .flush       (flush),
        .mem_wait    (mem_wait),
        .exec        (exec),
        .mem_req     (mem_req),
        .rf_wr       (rf_wr),
        .csr_wr      (csr_wr),
        .jmp         (jmp),
        .error_count (checker_errors),
        .idle        (model_idle)
    );

    // any request, write or redirect still coming out of the DUT
    assign dut_active = mem_req.rd_en || mem_req.wr_en || rf_wr.valid || csr_wr.valid ||
                        jmp.take;

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h9e37_79b1 * (i + 1);
        end
    end

    // data memory model with rdata one cycle after an accepted read
    always @(posedge CLK) begin
        if (rst_n && !mem_wait) begin
            if (mem_req.wr_en) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (mem_req.strb[lane]) begin
                        mem[mem_req.addr[9:2]][lane*8 +: 8] <= mem_req.wdata[lane*8 +: 8];
                    end
                end
            end
            if (mem_req.rd_en) begin
                rdata <= mem[mem_req.addr[9:2]];
            end
        end
    end

    // one execute result with at most one memory access
    task automatic make_item(output exec_bundle_t it);
        int unsigned kind;
        int unsigned sz;
        strb_t       size;
        logic [1:0]  ofs;
        word_t       addr;
        it              = '0;
        it.reg_wr.valid = ($urandom_range(0, 99) < 50);
        it.reg_wr.rd    = reg_addr_t'($urandom_range(0, 31));
        it.reg_wr.data  = $urandom;
        it.csr_wr.valid = ($urandom_range(0, 99) < 25);
        it.csr_wr.addr  = csr_addr_t'($urandom);
        it.csr_wr.data  = $urandom;
        it.jmp.take     = ($urandom_range(0, 99) < 15);
        it.jmp.pc       = $urandom & 32'hffff_fffc;

        // bytes at any offset, halves at 0 or 2 and words at 0
        sz   = $urandom_range(0, 2);
        size = (sz == 0) ? 4'b0001 : (sz == 1) ? 4'b0011 : 4'b1111;
        if (sz == 0) begin
            ofs = 2'($urandom_range(0, 3));
        end else if (sz == 1) begin
            ofs = ($urandom_range(0, 1) == 1) ? 2'b10 : 2'b00;
        end else begin
            ofs = 2'b00;
        end
        // few words so loads often hit earlier stores
        addr = {22'h0, 8'($urandom_range(0, 15)), ofs};

        kind = $urandom_range(0, 3);
        if (kind == 1) begin
            it.mem_rd.valid     = 1'b1;
            it.mem_rd.rd        = reg_addr_t'($urandom_range(0, 31));
            it.mem_rd.addr      = addr;
            it.mem_rd.strb      = size;
            it.mem_rd.signed_ld = 1'($urandom_range(0, 1));
            it.reg_wr.valid     = 1'b0;
        end else if (kind == 2) begin
            it.mem_wr.valid = 1'b1;
            it.mem_wr.addr  = addr;
            it.mem_wr.strb  = size;
            it.mem_wr.data  = $urandom;
        end
    endtask

    initial begin
        exec_bundle_t item;
        int           waited;
        void'($urandom(49));
        tb_errors = 0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        mem_wait  = 1'b0;
        exec      = '0;
        rdata     = '0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;

        for (int n = 0; n < NUM_CYCLES; n++) begin
            make_item(item);
            exec     = item;
            flush    = ($urandom_range(0, 99) < 4);
            mem_wait = (mem_req.rd_en || mem_req.wr_en) && ($urandom_range(0, 99) < 35);
            @(negedge CLK);
        end

        // let the last items leave the pipeline
        exec     = '0;
        flush    = 1'b0;
        mem_wait = 1'b0;
        waited   = 0;
        while ((!model_idle || dut_active) && waited < DRAIN_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        if (!model_idle || dut_active) begin
            tb_errors++;
            $display("pipeline did not drain within %0d cycles", DRAIN_LIMIT);
        end
        @(negedge CLK);

        $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
src/backend_pkg.sv
src/pipe_cushion.sv
src/mem_access.sv
src/load_writeback.sv
src/backend_top.sv
verification/backend_checker.sv
verification/backend_tb.sv

// File: Bender.yml
package:
  name: rv32i_backend

sources:
  - src/backend_pkg.sv
  - src/pipe_cushion.sv
  - src/mem_access.sv
  - src/load_writeback.sv
  - src/backend_top.sv
  - target: simulation
    files:
      - verification/backend_checker.sv
      - verification/backend_tb.sv
